/* src/mrd_data_pkg.sv */
// Data package for the mixed-radix memory with sample widths and component types
package mrd_data_pkg;

	// ------------------------------------------------------------------------
	// Component widths
	// ------------------------------------------------------------------------

	// Input sample component, as driven at the sink
	localparam int IN_W = 16;

	// Stored component
	// 16 bits plus growth of 64 over three radix-4 passes, with headroom
	localparam int ACC_W = 24;

	// ------------------------------------------------------------------------
	// Component types
	// ------------------------------------------------------------------------

	// One signed input component
	typedef logic signed [IN_W-1:0] in_sample_t;

	// One signed stored or output component
	typedef logic signed [ACC_W-1:0] acc_t;

endpackage

/* src/mrd_seq_pkg.sv */
// Sequencing package for the mixed-radix memory with radix codes, limits and FSM states
package mrd_seq_pkg;

	// ------------------------------------------------------------------------
	// Limits
	// ------------------------------------------------------------------------

	// At most three butterfly passes
	localparam int MAX_STAGES = 3;

	// Largest packet is 4*4*4 points
	localparam int MAX_PTS_LOG2 = 6;

	// RAM address
	typedef logic [MAX_PTS_LOG2-1:0] addr_t;

	// Stage index, also used for the stage count
	typedef logic [1:0] stage_t;

	// Radix code of one stage
	typedef logic [1:0] radix_t;

	localparam radix_t RADIX_NONE = 2'd0;
	localparam radix_t RADIX_2    = 2'd1;
	localparam radix_t RADIX_4    = 2'd2;

	// Top level packet FSM
	typedef enum logic [2:0] {
		IDLE        = 3'd0,
		SINK        = 3'd1,
		RD          = 3'd2,
		WAIT_WR_END = 3'd3,
		SOURCE      = 3'd4
	} mem_state_t;

endpackage

/* src/mrd_sample_ram.sv */
// Sample RAM holding one packet of complex words with one write port and a registered read port
`timescale 1ns/1ps

module mrd_sample_ram #(
	parameter int ADDR_W = 6
) (
	input  logic                clk,
	input  logic                wr_en,
	input  logic [ADDR_W-1:0]   wr_addr,
	input  mrd_data_pkg::acc_t  wr_real,
	input  mrd_data_pkg::acc_t  wr_imag,
	input  logic                rd_en,
	input  logic [ADDR_W-1:0]   rd_addr,
	output mrd_data_pkg::acc_t  rd_real,
	output mrd_data_pkg::acc_t  rd_imag
);

	localparam int DEPTH = 1 << ADDR_W;
	localparam int WORD_W = 2 * mrd_data_pkg::ACC_W;

	// Real part in the upper half of each word
	logic [WORD_W-1:0] mem [0:DEPTH-1];
	logic [WORD_W-1:0] rd_word;

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_addr] <= {wr_real, wr_imag};
		// Output register holds its value between reads
		if (rd_en)
			rd_word <= mem[rd_addr];
	end

	assign rd_real = rd_word[WORD_W-1:mrd_data_pkg::ACC_W];
	assign rd_imag = rd_word[mrd_data_pkg::ACC_W-1:0];

endmodule

/* src/mrd_stage_addr_gen.sv */
// Pass address generator walking the blocks and groups of one butterfly pass
`timescale 1ns/1ps

module mrd_stage_addr_gen #(
	parameter int ADDR_W = 6
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start,
	input  mrd_seq_pkg::radix_t  radix,
	input  logic [ADDR_W:0]      span,
	input  logic [ADDR_W:0]      pts,
	output logic                 rd_en,
	output logic [ADDR_W-1:0]    rd_addr,
	output logic                 grp_last,
	output logic                 rd_end
);

	logic            active;
	// Block base, group offset j and current read address
	logic [ADDR_W:0] base;
	logic [ADDR_W:0] offs;
	logic [ADDR_W:0] addr;
	// Distance between the points of one group, L/r
	logic [ADDR_W:0] stride;
	logic [1:0]      step;
	logic [1:0]      step_max;
	logic            grp_done;
	logic            blk_done;
	logic            pass_done;

	assign stride   = (radix == mrd_seq_pkg::RADIX_4) ? (span >> 2) : (span >> 1);
	assign step_max = (radix == mrd_seq_pkg::RADIX_4) ? 2'd3 : 2'd1;

	// Last point of a group, of a block, of the pass
	assign grp_done  = active && (step == step_max);
	assign blk_done  = grp_done && (offs == stride - 1'b1);
	assign pass_done = blk_done && (base + span == pts);

	// ------------------------------------------------------------------------
	// Counters
	// ------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			active <= 1'b0;
			base   <= '0;
			offs   <= '0;
			addr   <= '0;
			step   <= '0;
		end
		else if (start)
		begin
			active <= 1'b1;
			base   <= '0;
			offs   <= '0;
			addr   <= '0;
			step   <= '0;
		end
		else if (active)
		begin
			if (pass_done)
				active <= 1'b0;
			else if (blk_done)
			begin
				// Next block starts at group 0
				base <= base + span;
				offs <= '0;
				addr <= base + span;
				step <= '0;
			end
			else if (grp_done)
			begin
				// Next group in the same block
				offs <= offs + 1'b1;
				addr <= base + offs + 1'b1;
				step <= '0;
			end
			else
			begin
				addr <= addr + stride;
				step <= step + 1'b1;
			end
		end
	end

	// One read per active cycle
	assign rd_en    = active;
	assign rd_addr  = addr[ADDR_W-1:0];
	assign grp_last = grp_done;
	assign rd_end   = pass_done;

endmodule

/* src/mrd_butterfly.sv */
// Radix-2/radix-4 butterfly collecting one group and writing its results back serially
`timescale 1ns/1ps

module mrd_butterfly (
	input  logic                 clk,
	input  logic                 rst_n,
	input  mrd_seq_pkg::radix_t  radix,
	input  logic                 din_valid,
	input  logic                 din_last,
	input  mrd_seq_pkg::addr_t   din_addr,
	input  mrd_data_pkg::acc_t   din_real,
	input  mrd_data_pkg::acc_t   din_imag,
	output logic                 wr_en,
	output mrd_seq_pkg::addr_t   wr_addr,
	output mrd_data_pkg::acc_t   wr_real,
	output mrd_data_pkg::acc_t   wr_imag,
	output logic                 idle
);

	// Collect buffer, newest sample at index 0
	mrd_data_pkg::acc_t col_re [0:2];
	mrd_data_pkg::acc_t col_im [0:2];
	mrd_seq_pkg::addr_t col_addr [0:2];
	logic [1:0]         col_cnt;

	// Kernel inputs a..d in group order
	mrd_data_pkg::acc_t k_re [0:3];
	mrd_data_pkg::acc_t k_im [0:3];
	mrd_seq_pkg::addr_t k_addr [0:3];
	mrd_data_pkg::acc_t x_re [0:3];
	mrd_data_pkg::acc_t x_im [0:3];

	// Output buffer, drained from index 0
	mrd_data_pkg::acc_t out_re [0:3];
	mrd_data_pkg::acc_t out_im [0:3];
	mrd_seq_pkg::addr_t out_addr [0:3];
	logic [2:0]         out_cnt;

	// ------------------------------------------------------------------------
	// Kernel
	// ------------------------------------------------------------------------
	always_comb
	begin
		if (radix == mrd_seq_pkg::RADIX_4)
		begin
			for (int i = 0; i < 3; i++)
			begin
				k_re[i]   = col_re[2-i];
				k_im[i]   = col_im[2-i];
				k_addr[i] = col_addr[2-i];
			end
			k_re[3]   = din_real;
			k_im[3]   = din_imag;
			k_addr[3] = din_addr;
			// X1 and X3 take the -j and +j rotations of b and d
			x_re[0] = k_re[0] + k_re[1] + k_re[2] + k_re[3];
			x_im[0] = k_im[0] + k_im[1] + k_im[2] + k_im[3];
			x_re[1] = k_re[0] + k_im[1] - k_re[2] - k_im[3];
			x_im[1] = k_im[0] - k_re[1] - k_im[2] + k_re[3];
			x_re[2] = k_re[0] - k_re[1] + k_re[2] - k_re[3];
			x_im[2] = k_im[0] - k_im[1] + k_im[2] - k_im[3];
			x_re[3] = k_re[0] - k_im[1] - k_re[2] + k_im[3];
			x_im[3] = k_im[0] + k_re[1] - k_im[2] - k_re[3];
		end
		else
		begin
			k_re[0]   = col_re[0];
			k_im[0]   = col_im[0];
			k_addr[0] = col_addr[0];
			k_re[1]   = din_real;
			k_im[1]   = din_imag;
			k_addr[1] = din_addr;
			// Upper two slots unused
			k_re[2]   = '0;
			k_im[2]   = '0;
			k_addr[2] = '0;
			k_re[3]   = '0;
			k_im[3]   = '0;
			k_addr[3] = '0;
			x_re[0] = k_re[0] + k_re[1];
			x_im[0] = k_im[0] + k_im[1];
			x_re[1] = k_re[0] - k_re[1];
			x_im[1] = k_im[0] - k_im[1];
			x_re[2] = '0;
			x_im[2] = '0;
			x_re[3] = '0;
			x_im[3] = '0;
		end
	end

	// ------------------------------------------------------------------------
	// Buffer payload
	// ------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (din_valid)
		begin
			for (int i = 2; i > 0; i--)
			begin
				col_re[i]   <= col_re[i-1];
				col_im[i]   <= col_im[i-1];
				col_addr[i] <= col_addr[i-1];
			end
			col_re[0]   <= din_real;
			col_im[0]   <= din_imag;
			col_addr[0] <= din_addr;
		end
		// Load on the last sample, otherwise shift one write out
		if (din_valid && din_last)
		begin
			out_re   <= x_re;
			out_im   <= x_im;
			out_addr <= k_addr;
		end
		else if (out_cnt != 3'd0)
		begin
			for (int i = 0; i < 3; i++)
			begin
				out_re[i]   <= out_re[i+1];
				out_im[i]   <= out_im[i+1];
				out_addr[i] <= out_addr[i+1];
			end
		end
	end

	// Fill levels
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			col_cnt <= '0;
			out_cnt <= '0;
		end
		else
		begin
			if (din_valid)
				col_cnt <= din_last ? 2'd0 : col_cnt + 1'b1;
			if (din_valid && din_last)
				out_cnt <= (radix == mrd_seq_pkg::RADIX_4) ? 3'd4 : 3'd2;
			else if (out_cnt != 3'd0)
				out_cnt <= out_cnt - 1'b1;
		end
	end

	assign wr_en   = (out_cnt != 3'd0);
	assign wr_addr = out_addr[0];
	assign wr_real = out_re[0];
	assign wr_imag = out_im[0];
	assign idle    = (col_cnt == 2'd0) && (out_cnt == 3'd0);

endmodule

/* src/mrd_mem_top.sv */
// Mixed-radix memory top sequencing sink, in-place butterfly passes and source on one RAM
`timescale 1ns/1ps

module mrd_mem_top #(
	parameter int ADDR_W = mrd_seq_pkg::MAX_PTS_LOG2
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       in_valid,
	input  logic                       in_sop,
	input  mrd_data_pkg::in_sample_t   in_real,
	input  mrd_data_pkg::in_sample_t   in_imag,
	input  mrd_seq_pkg::stage_t        cfg_num_stages,
	input  mrd_seq_pkg::radix_t [0:mrd_seq_pkg::MAX_STAGES-1] cfg_radix,
	output logic                       out_valid,
	output logic                       out_sop,
	output logic                       out_eop,
	output mrd_data_pkg::acc_t         out_real,
	output mrd_data_pkg::acc_t         out_imag,
	output logic                       busy
);

	localparam int PTS_W = ADDR_W + 1;

	mrd_seq_pkg::mem_state_t state;
	mrd_seq_pkg::mem_state_t state_nxt;

	// Packet configuration
	mrd_seq_pkg::radix_t [0:mrd_seq_pkg::MAX_STAGES-1] radix_r;
	mrd_seq_pkg::stage_t num_stages_r;
	mrd_seq_pkg::stage_t stage_cnt;
	mrd_seq_pkg::radix_t cur_radix;
	logic [ADDR_W:0]     pts_w;
	logic [ADDR_W:0]     pts_r;
	logic [ADDR_W:0]     span_r;

	// Sink side
	logic                sink_acc;
	logic [ADDR_W:0]     sink_cnt;
	logic                sink_we_r;
	logic [ADDR_W-1:0]   sink_addr_r;
	mrd_data_pkg::acc_t  sink_re_r;
	mrd_data_pkg::acc_t  sink_im_r;
	logic                sink_done;

	// Pass side
	logic                ag_start;
	logic                ag_rd_en;
	logic [ADDR_W-1:0]   ag_rd_addr;
	logic                ag_grp_last;
	logic                ag_rd_end;
	logic                bf_din_valid;
	logic                bf_din_last;
	mrd_seq_pkg::addr_t  bf_din_addr;
	logic                bf_wr_en;
	mrd_seq_pkg::addr_t  bf_wr_addr;
	mrd_data_pkg::acc_t  bf_wr_re;
	mrd_data_pkg::acc_t  bf_wr_im;
	logic                bf_idle;

	// RAM ports
	logic                ram_wr_en;
	logic [ADDR_W-1:0]   ram_wr_addr;
	mrd_data_pkg::acc_t  ram_wr_re;
	mrd_data_pkg::acc_t  ram_wr_im;
	logic                ram_rd_en;
	logic [ADDR_W-1:0]   ram_rd_addr;
	mrd_data_pkg::acc_t  ram_rd_re;
	mrd_data_pkg::acc_t  ram_rd_im;

	// Source side
	logic [ADDR_W:0]     src_cnt;
	logic                src_rd;
	logic                src_rd_d;
	logic                src_sop_d;
	logic                src_eop_d;

	// N as a power of two from the radices in use
	function automatic logic [ADDR_W:0] packet_len(
		input mrd_seq_pkg::stage_t n,
		input mrd_seq_pkg::radix_t [0:mrd_seq_pkg::MAX_STAGES-1] rdx
	);
		int lg;
		lg = 0;
		for (int s = 0; s < mrd_seq_pkg::MAX_STAGES; s++)
		begin
			if (s < n && rdx[s] == mrd_seq_pkg::RADIX_4)
				lg += 2;
			else if (s < n && rdx[s] == mrd_seq_pkg::RADIX_2)
				lg += 1;
		end
		return PTS_W'(1) << lg;
	endfunction

	assign pts_w     = packet_len(cfg_num_stages, cfg_radix);
	assign cur_radix = radix_r[stage_cnt];

	// Sample 0 comes with the sop and the rest up to N in SINK
	assign sink_acc  = in_valid && ((state == mrd_seq_pkg::IDLE && in_sop) ||
		(state == mrd_seq_pkg::SINK && sink_cnt != pts_r));
	// Last sink write happens this cycle
	assign sink_done = sink_we_r && (sink_addr_r == pts_r - 1'b1);

	assign src_rd = (state == mrd_seq_pkg::SOURCE) && (src_cnt != pts_r);
	assign busy   = (state != mrd_seq_pkg::IDLE);

	// ------------------------------------------------------------------------
	// Packet FSM
	// ------------------------------------------------------------------------
	always_comb
	begin
		state_nxt = state;
		case (state)
			mrd_seq_pkg::IDLE:
				if (in_valid && in_sop)
					state_nxt = mrd_seq_pkg::SINK;
			mrd_seq_pkg::SINK:
				if (sink_done)
					state_nxt = mrd_seq_pkg::RD;
			mrd_seq_pkg::RD:
				if (ag_rd_end)
					state_nxt = mrd_seq_pkg::WAIT_WR_END;
			mrd_seq_pkg::WAIT_WR_END:
				// Next pass or read out once the butterfly has drained
				if (bf_idle)
					state_nxt = (stage_cnt == num_stages_r - 1'b1) ?
						mrd_seq_pkg::SOURCE : mrd_seq_pkg::RD;
			mrd_seq_pkg::SOURCE:
				if (out_eop)
					state_nxt = mrd_seq_pkg::IDLE;
			default:
				state_nxt = mrd_seq_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state        <= mrd_seq_pkg::IDLE;
			ag_start     <= 1'b0;
			radix_r      <= '0;
			num_stages_r <= '0;
			pts_r        <= '0;
			span_r       <= '0;
			stage_cnt    <= '0;
			sink_cnt     <= '0;
			sink_we_r    <= 1'b0;
			bf_din_valid <= 1'b0;
			bf_din_last  <= 1'b0;
			src_cnt      <= '0;
			src_rd_d     <= 1'b0;
			src_sop_d    <= 1'b0;
			src_eop_d    <= 1'b0;
			out_valid    <= 1'b0;
			out_sop      <= 1'b0;
			out_eop      <= 1'b0;
		end
		else
		begin
			state    <= state_nxt;
			// Pulse in the first cycle of each pass
			ag_start <= (state_nxt == mrd_seq_pkg::RD) && (state != mrd_seq_pkg::RD);

			// Configuration at sop and a span that shrinks by r after each pass
			if (state == mrd_seq_pkg::IDLE && in_valid && in_sop)
			begin
				radix_r      <= cfg_radix;
				num_stages_r <= cfg_num_stages;
				pts_r        <= pts_w;
				span_r       <= pts_w;
				stage_cnt    <= '0;
			end
			else if (state == mrd_seq_pkg::WAIT_WR_END && state_nxt == mrd_seq_pkg::RD)
			begin
				stage_cnt <= stage_cnt + 1'b1;
				span_r    <= (cur_radix == mrd_seq_pkg::RADIX_4) ? (span_r >> 2) : (span_r >> 1);
			end

			// Sink counter
			sink_we_r <= sink_acc;
			if (sink_acc)
				sink_cnt <= (state == mrd_seq_pkg::IDLE) ? PTS_W'(1) : sink_cnt + 1'b1;

			// Read strobe and group framing follow the RAM latency
			bf_din_valid <= ag_rd_en;
			bf_din_last  <= ag_grp_last;

			// Source counter and two-stage output framing
			if (state != mrd_seq_pkg::SOURCE)
				src_cnt <= '0;
			else if (src_rd)
				src_cnt <= src_cnt + 1'b1;
			src_rd_d  <= src_rd;
			src_sop_d <= src_rd && (src_cnt == '0);
			src_eop_d <= src_rd && (src_cnt == pts_r - 1'b1);
			out_valid <= src_rd_d;
			out_sop   <= src_sop_d;
			out_eop   <= src_eop_d;
		end
	end

	// ------------------------------------------------------------------------
	// Payload registers
	// ------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (sink_acc)
		begin
			sink_addr_r <= (state == mrd_seq_pkg::IDLE) ? '0 : sink_cnt[ADDR_W-1:0];
			// Sign extension to the stored width
			sink_re_r   <= mrd_data_pkg::acc_t'(in_real);
			sink_im_r   <= mrd_data_pkg::acc_t'(in_imag);
		end
		bf_din_addr <= mrd_seq_pkg::addr_t'(ag_rd_addr);
		out_real    <= ram_rd_re;
		out_imag    <= ram_rd_im;
	end

	// ------------------------------------------------------------------------
	// RAM port multiplexing
	// ------------------------------------------------------------------------
	assign ram_wr_en   = (state == mrd_seq_pkg::SINK) ? sink_we_r : bf_wr_en;
	assign ram_wr_addr = (state == mrd_seq_pkg::SINK) ? sink_addr_r : ADDR_W'(bf_wr_addr);
	assign ram_wr_re   = (state == mrd_seq_pkg::SINK) ? sink_re_r : bf_wr_re;
	assign ram_wr_im   = (state == mrd_seq_pkg::SINK) ? sink_im_r : bf_wr_im;
	assign ram_rd_en   = (state == mrd_seq_pkg::RD) ? ag_rd_en : src_rd;
	assign ram_rd_addr = (state == mrd_seq_pkg::RD) ? ag_rd_addr : src_cnt[ADDR_W-1:0];

	mrd_sample_ram #(
		.ADDR_W (ADDR_W)
	) u_ram (
		.clk     (clk),
		.wr_en   (ram_wr_en),
		.wr_addr (ram_wr_addr),
		.wr_real (ram_wr_re),
		.wr_imag (ram_wr_im),
		.rd_en   (ram_rd_en),
		.rd_addr (ram_rd_addr),
		.rd_real (ram_rd_re),
		.rd_imag (ram_rd_im)
	);

	mrd_stage_addr_gen #(
		.ADDR_W (ADDR_W)
	) u_addr_gen (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (ag_start),
		.radix    (cur_radix),
		.span     (span_r),
		.pts      (pts_r),
		.rd_en    (ag_rd_en),
		.rd_addr  (ag_rd_addr),
		.grp_last (ag_grp_last),
		.rd_end   (ag_rd_end)
	);

	mrd_butterfly u_butterfly (
		.clk       (clk),
		.rst_n     (rst_n),
		.radix     (cur_radix),
		.din_valid (bf_din_valid),
		.din_last  (bf_din_last),
		.din_addr  (bf_din_addr),
		.din_real  (ram_rd_re),
		.din_imag  (ram_rd_im),
		.wr_en     (bf_wr_en),
		.wr_addr   (bf_wr_addr),
		.wr_real   (bf_wr_re),
		.wr_imag   (bf_wr_im),
		.idle      (bf_idle)
	);

endmodule

/* test/mrd_tb.sv */
// Testbench for the mixed-radix memory top with stage cascade model, comparator and watchdog
`timescale 1ns/1ps

module mrd_tb;

	// ------------------------------------------------------------------------
	// Test table with one packet per entry
	// ------------------------------------------------------------------------
	localparam int NUM_TESTS = 11;
	localparam int MAX_PTS = 1 << mrd_seq_pkg::MAX_PTS_LOG2;
	// Stage count and radix list with unused radix slots at 0
	localparam int TEST_NS [0:NUM_TESTS-1] = '{1, 2, 3, 1, 2, 2, 3, 3, 3, 3, 2};
	localparam int TEST_R0 [0:NUM_TESTS-1] = '{2, 2, 2, 4, 4, 4, 2, 2, 4, 4, 2};
	localparam int TEST_R1 [0:NUM_TESTS-1] = '{0, 2, 2, 0, 4, 2, 4, 4, 4, 2, 4};
	localparam int TEST_R2 [0:NUM_TESTS-1] = '{0, 0, 2, 0, 0, 0, 4, 4, 4, 4, 0};
	// Gap entries resend the data of the entry before
	localparam int TEST_GAPS [0:NUM_TESTS-1] = '{0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0};
	localparam int RESET_CYCLES = 5;
	localparam int SETUP_CYCLES = 20;
	// Sop and samples driven while the packet is processed
	localparam int JUNK_CYCLES = 6;

	logic                                              clk;
	logic                                              rst_n;
	logic                                              in_valid;
	logic                                              in_sop;
	mrd_data_pkg::in_sample_t                          in_real;
	mrd_data_pkg::in_sample_t                          in_imag;
	mrd_seq_pkg::stage_t                               cfg_num_stages;
	mrd_seq_pkg::radix_t [0:mrd_seq_pkg::MAX_STAGES-1] cfg_radix;
	logic                                              out_valid;
	logic                                              out_sop;
	logic                                              out_eop;
	mrd_data_pkg::acc_t                                out_real;
	mrd_data_pkg::acc_t                                out_imag;
	logic                                              busy;

	integer seed;
	// Input packet and expected memory-order result
	int     pkt_re [0:MAX_PTS-1];
	int     pkt_im [0:MAX_PTS-1];
	int     exp_re [0:MAX_PTS-1];
	int     exp_im [0:MAX_PTS-1];
	int     exp_len;
	int     pkts_sent;
	// Comparator side
	int     pkts_done;
	int     out_idx;
	logic   eop_prev;

	mrd_mem_top #(
		.ADDR_W (mrd_seq_pkg::MAX_PTS_LOG2)
	) uut (
		.clk            (clk),
		.rst_n          (rst_n),
		.in_valid       (in_valid),
		.in_sop         (in_sop),
		.in_real        (in_real),
		.in_imag        (in_imag),
		.cfg_num_stages (cfg_num_stages),
		.cfg_radix      (cfg_radix),
		.out_valid      (out_valid),
		.out_sop        (out_sop),
		.out_eop        (out_eop),
		.out_real       (out_real),
		.out_imag       (out_imag),
		.busy           (busy)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------------
	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1, "run stopped at the first error");
	endtask

	function automatic mrd_seq_pkg::radix_t radix_code(input int r);
		if (r == 4)
			return mrd_seq_pkg::RADIX_4;
		else if (r == 2)
			return mrd_seq_pkg::RADIX_2;
		return mrd_seq_pkg::RADIX_NONE;
	endfunction

	// N is the product of the radices in use
	function automatic int packet_points(input int ns, input int r0, input int r1, input int r2);
		int n;
		n = r0;
		if (ns > 1)
			n = n * r1;
		if (ns > 2)
			n = n * r2;
		return n;
	endfunction

	// Cycle budget of 4*N*(stages+2) per packet
	function automatic int watchdog_cycles();
		int total;
		int t;
		total = SETUP_CYCLES;
		for (t = 0; t < NUM_TESTS; t++)
			total += 4 * packet_points(TEST_NS[t], TEST_R0[t], TEST_R1[t], TEST_R2[t]) *
				(TEST_NS[t] + 2);
		return total;
	endfunction

	// ------------------------------------------------------------------------
	// Reference model of the twiddle-free stage cascade
	// ------------------------------------------------------------------------
	function automatic void model_stage_cascade(input int n, input int ns, input int r0,
		input int r1, input int r2);
		int rl [0:2];
		int a_re [0:3];
		int a_im [0:3];
		int x_re [0:3];
		int x_im [0:3];
		int mjb_re;
		int mjb_im;
		int pjd_re;
		int pjd_im;
		int p;
		int l;
		int q;
		int r;
		int s;
		int base;
		int j;
		int k;
		rl[0] = r0;
		rl[1] = r1;
		rl[2] = r2;
		for (k = 0; k < n; k++)
		begin
			exp_re[k] = pkt_re[k];
			exp_im[k] = pkt_im[k];
		end
		// P grows by r per stage and sets the block length L = N/P
		p = 1;
		for (s = 0; s < ns; s++)
		begin
			r = rl[s];
			l = n / p;
			q = l / r;
			for (base = 0; base < n; base += l)
			begin
				for (j = 0; j < q; j++)
				begin
					// Group j with points spaced by L/r
					for (k = 0; k < r; k++)
					begin
						a_re[k] = exp_re[base + j + k * q];
						a_im[k] = exp_im[base + j + k * q];
					end
					if (r == 2)
					begin
						x_re[0] = a_re[0] + a_re[1];
						x_im[0] = a_im[0] + a_im[1];
						x_re[1] = a_re[0] - a_re[1];
						x_im[1] = a_im[0] - a_im[1];
					end
					else
					begin
						// Rotations -j*b and +j*d of the radix-4 kernel
						mjb_re = a_im[1];
						mjb_im = -a_re[1];
						pjd_re = -a_im[3];
						pjd_im = a_re[3];
						x_re[0] = a_re[0] + a_re[1] + a_re[2] + a_re[3];
						x_im[0] = a_im[0] + a_im[1] + a_im[2] + a_im[3];
						x_re[1] = a_re[0] + mjb_re - a_re[2] + pjd_re;
						x_im[1] = a_im[0] + mjb_im - a_im[2] + pjd_im;
						x_re[2] = a_re[0] - a_re[1] + a_re[2] - a_re[3];
						x_im[2] = a_im[0] - a_im[1] + a_im[2] - a_im[3];
						// +j*b and -j*d are the same rotations negated
						x_re[3] = a_re[0] - mjb_re - a_re[2] - pjd_re;
						x_im[3] = a_im[0] - mjb_im - a_im[2] - pjd_im;
					end
					for (k = 0; k < r; k++)
					begin
						exp_re[base + j + k * q] = x_re[k];
						exp_im[base + j + k * q] = x_im[k];
					end
				end
			end
			p = p * r;
		end
	endfunction

	// ------------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------------
	task automatic send_packet(input int n, input int ns, input int r0, input int r1,
		input int r2, input int gaps);
		int idx;
		int k;
		idx = 1;
		@(posedge clk);
		#1;
		// Sample 0 with sop and configuration
		cfg_num_stages = mrd_seq_pkg::stage_t'(ns);
		cfg_radix[0]   = radix_code(r0);
		cfg_radix[1]   = radix_code(ns > 1 ? r1 : 0);
		cfg_radix[2]   = radix_code(ns > 2 ? r2 : 0);
		in_valid       = 1'b1;
		in_sop         = 1'b1;
		in_real        = mrd_data_pkg::in_sample_t'(pkt_re[0]);
		in_imag        = mrd_data_pkg::in_sample_t'(pkt_im[0]);
		while (idx < n)
		begin
			@(posedge clk);
			#1;
			in_sop = 1'b0;
			if (gaps != 0 && ($random(seed) & 1) == 0)
			begin
				in_valid = 1'b0;
				in_real  = mrd_data_pkg::in_sample_t'($random(seed));
				in_imag  = mrd_data_pkg::in_sample_t'($random(seed));
			end
			else
			begin
				in_valid = 1'b1;
				in_real  = mrd_data_pkg::in_sample_t'(pkt_re[idx]);
				in_imag  = mrd_data_pkg::in_sample_t'(pkt_im[idx]);
				idx++;
			end
		end
		// Stray sop, data and config that the DUT has to ignore
		repeat (JUNK_CYCLES)
		begin
			@(posedge clk);
			#1;
			in_valid       = 1'b1;
			in_sop         = 1'b1;
			in_real        = mrd_data_pkg::in_sample_t'($random(seed));
			in_imag        = mrd_data_pkg::in_sample_t'($random(seed));
			cfg_num_stages = mrd_seq_pkg::stage_t'(3);
			for (k = 0; k < mrd_seq_pkg::MAX_STAGES; k++)
				cfg_radix[k] = mrd_seq_pkg::RADIX_4;
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		in_sop   = 1'b0;
	endtask

	task automatic wait_packet_end();
		@(posedge clk);
		#1;
		while (busy)
		begin
			@(posedge clk);
			#1;
		end
		assert (pkts_done == pkts_sent)
		else stop_with_error("busy fell before the packet's outputs were complete");
	endtask

	initial
	begin
		int t;
		int n;
		int i;
		seed           = 32'h468152c6;
		rst_n          = 1'b0;
		in_valid       = 1'b0;
		in_sop         = 1'b0;
		in_real        = '0;
		in_imag        = '0;
		cfg_num_stages = '0;
		cfg_radix      = '0;
		exp_len        = 0;
		pkts_sent      = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// Quiet outputs before the first sop
		repeat (4)
		begin
			@(posedge clk);
			#1;
			assert (!out_valid && !out_sop && !out_eop && !busy)
			else stop_with_error("output strobe or busy high after reset before any sop");
		end
		for (t = 0; t < NUM_TESTS; t++)
		begin
			n = packet_points(TEST_NS[t], TEST_R0[t], TEST_R1[t], TEST_R2[t]);
			if (TEST_GAPS[t] == 0)
			begin
				for (i = 0; i < n; i++)
				begin
					pkt_re[i] = $random(seed) % 32768;
					pkt_im[i] = $random(seed) % 32768;
				end
			end
			model_stage_cascade(n, TEST_NS[t], TEST_R0[t], TEST_R1[t], TEST_R2[t]);
			exp_len = n;
			pkts_sent++;
			send_packet(n, TEST_NS[t], TEST_R0[t], TEST_R1[t], TEST_R2[t], TEST_GAPS[t]);
			wait_packet_end();
		end
		repeat (2) @(posedge clk);
		#1;
		$display("PASS: all tests");
		$finish;
	end

	// ------------------------------------------------------------------------
	// Comparator sampling in the middle of the cycle
	// ------------------------------------------------------------------------
	always @(negedge clk)
	begin
		if (!rst_n)
		begin
			pkts_done = 0;
			out_idx   = 0;
			eop_prev  = 1'b0;
		end
		else
		begin
			if (eop_prev)
			begin
				assert (!busy)
				else stop_with_error("busy still high in the cycle after out_eop");
				eop_prev = 1'b0;
			end
			assert (out_valid || (!out_sop && !out_eop))
			else stop_with_error("out_sop or out_eop high without out_valid");
			if (out_valid)
			begin
				assert (pkts_sent > pkts_done)
				else stop_with_error("out_valid high with no packet in progress");
				assert (out_idx < exp_len)
				else stop_with_error($sformatf("more than %0d outputs in one packet", exp_len));
				assert (out_sop == (out_idx == 0))
				else stop_with_error($sformatf("out_sop misplaced at output %0d", out_idx));
				assert (out_eop == (out_idx == exp_len - 1))
				else stop_with_error($sformatf("out_eop misplaced at output %0d of %0d",
					out_idx, exp_len));
				assert (out_real == mrd_data_pkg::acc_t'(exp_re[out_idx]))
				else stop_with_error($sformatf("mismatch out_real at output %0d: got %h expected %h",
					out_idx, out_real, mrd_data_pkg::acc_t'(exp_re[out_idx])));
				assert (out_imag == mrd_data_pkg::acc_t'(exp_im[out_idx]))
				else stop_with_error($sformatf("mismatch out_imag at output %0d: got %h expected %h",
					out_idx, out_imag, mrd_data_pkg::acc_t'(exp_im[out_idx])));
				if (out_eop)
				begin
					pkts_done++;
					out_idx  = 0;
					eop_prev = 1'b1;
				end
				else
					out_idx++;
			end
		end
	end

	// Watchdog over the summed packet budgets
	initial
	begin
		repeat (watchdog_cycles()) @(posedge clk);
		stop_with_error($sformatf("timeout, run not finished after %0d cycles", watchdog_cycles()));
	end

endmodule

/* verilog.f */
src/mrd_data_pkg.sv
src/mrd_seq_pkg.sv
src/mrd_sample_ram.sv
src/mrd_stage_addr_gen.sv
src/mrd_butterfly.sv
src/mrd_mem_top.sv
test/mrd_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the mixed-radix memory testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module mrd_tb -f verilog.f

# A $fatal in the testbench gives a failing exit status
./obj_dir/Vmrd_tb
